// File: source/periph_pkg.sv
/*
 * Register-bus widths, region map, register offset enums
 * and the peripheral select enum
 */
package periph_pkg;

  // OBI data and address width
  parameter int unsigned BUS_WIDTH = 32;

  // Offset width inside one peripheral region
  parameter int unsigned REG_ADDR_WIDTH = 12;

  // Two region-select bits start here
  parameter int unsigned REGION_LSB = 12;

  parameter int unsigned PRIO_WIDTH = 3;

  typedef enum logic [1:0] {
    SEL_GPIO  = 2'd0,
    SEL_TIMER = 2'd1,
    SEL_PLIC  = 2'd2,
    SEL_NONE  = 2'd3
  } periph_sel_e;

  typedef enum logic [REG_ADDR_WIDTH-1:0] {
    GPIO_IN          = 12'h000,
    GPIO_OUT         = 12'h004,
    GPIO_OE          = 12'h008,
    GPIO_INTR_EN     = 12'h00C,
    GPIO_INTR_STATUS = 12'h010
  } gpio_reg_e;

  typedef enum logic [REG_ADDR_WIDTH-1:0] {
    TMR_CTRL     = 12'h000,
    TMR_PRESCALE = 12'h004,
    TMR_COUNT    = 12'h008,
    TMR_CMP0     = 12'h00C,
    TMR_CMP1     = 12'h010,
    TMR_INTR_EN  = 12'h014
  } timer_reg_e;

  // PLIC map, priority of source n sits at base plus 4*n
  parameter logic [REG_ADDR_WIDTH-1:0] PLIC_PRIO_BASE = 12'h000;
  parameter logic [REG_ADDR_WIDTH-1:0] PLIC_PENDING   = 12'h080;
  parameter logic [REG_ADDR_WIDTH-1:0] PLIC_ENABLE    = 12'h100;
  parameter logic [REG_ADDR_WIDTH-1:0] PLIC_THRESHOLD = 12'h200;
  parameter logic [REG_ADDR_WIDTH-1:0] PLIC_CLAIM     = 12'h204;
  parameter logic [REG_ADDR_WIDTH-1:0] PLIC_MSIP      = 12'h300;

endpackage : periph_pkg

// File: source/reg_bus_if.sv
/*
 * Internal register bus with host and device views
 */
`timescale 1ns/1ps

interface reg_bus_if;
  import periph_pkg::*;

  logic                      valid;
  logic                      write;
  logic [REG_ADDR_WIDTH-1:0] addr;
  logic [BUS_WIDTH-1:0]      wdata;
  // Driven combinationally by the device
  logic [BUS_WIDTH-1:0]      rdata;

  modport host (
    output valid, write, addr, wdata,
    input  rdata
  );

  modport device (
    input  valid, write, addr, wdata,
    output rdata
  );

endinterface : reg_bus_if

// File: source/obi_reg_bridge.sv
/*
 * OBI subordinate to register bus bridge
 * Never stalls, response arrives one cycle after the grant
 */
`timescale 1ns/1ps

module obi_reg_bridge (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [periph_pkg::BUS_WIDTH-1:0] addr_i,
  input  logic [periph_pkg::BUS_WIDTH-1:0] wdata_i,
  output logic                          gnt_o,
  output logic                          rvalid_o,
  output logic [periph_pkg::BUS_WIDTH-1:0] rdata_o,
  output periph_pkg::periph_sel_e       region_o,
  reg_bus_if.host                       bus
);
  import periph_pkg::*;

  logic                 rvalid_q;
  logic [BUS_WIDTH-1:0] rdata_q;

  // No wait states
  assign gnt_o = req_i;

  // Request goes straight onto the register bus
  assign bus.valid = req_i;
  assign bus.write = we_i;
  assign bus.addr  = addr_i[REG_ADDR_WIDTH-1:0];
  assign bus.wdata = wdata_i;

  assign region_o = periph_sel_e'(addr_i[REGION_LSB +: 2]);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= we_i ? '0 : bus.rdata;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule : obi_reg_bridge

// File: source/periph_reg_demux.sv
/*
 * Routes one register bus to the GPIO, timer and PLIC ports
 */
`timescale 1ns/1ps

module periph_reg_demux (
  input  periph_pkg::periph_sel_e region_i,
  reg_bus_if.device               bus_up,
  reg_bus_if.host                 bus_gpio,
  reg_bus_if.host                 bus_timer,
  reg_bus_if.host                 bus_plic
);
  import periph_pkg::*;

  // Request fields fan out unchanged
  assign bus_gpio.write  = bus_up.write;
  assign bus_gpio.addr   = bus_up.addr;
  assign bus_gpio.wdata  = bus_up.wdata;
  assign bus_timer.write = bus_up.write;
  assign bus_timer.addr  = bus_up.addr;
  assign bus_timer.wdata = bus_up.wdata;
  assign bus_plic.write  = bus_up.write;
  assign bus_plic.addr   = bus_up.addr;
  assign bus_plic.wdata  = bus_up.wdata;

  // Only the selected peripheral sees the access
  assign bus_gpio.valid  = bus_up.valid && (region_i == SEL_GPIO);
  assign bus_timer.valid = bus_up.valid && (region_i == SEL_TIMER);
  assign bus_plic.valid  = bus_up.valid && (region_i == SEL_PLIC);

  always_comb begin
    case (region_i)
      SEL_GPIO: begin
        bus_up.rdata = bus_gpio.rdata;
      end
      SEL_TIMER: begin
        bus_up.rdata = bus_timer.rdata;
      end
      SEL_PLIC: begin
        bus_up.rdata = bus_plic.rdata;
      end
      // Unmapped region reads as zero
      default: begin
        bus_up.rdata = '0;
      end
    endcase
  end

endmodule : periph_reg_demux

// File: source/gpio_regs.sv
/*
 * GPIO registers with input synchronizer and
 * rising-edge interrupts
 */
`timescale 1ns/1ps

module gpio_regs #(
  parameter int unsigned NumGpio = 8
) (
  input  logic               clk_i,
  input  logic               reset_i,
  reg_bus_if.device          bus,
  input  logic [NumGpio-1:0] gpio_i,
  output logic [NumGpio-1:0] gpio_o,
  output logic [NumGpio-1:0] gpio_en_o,
  output logic [NumGpio-1:0] intr_o
);
  import periph_pkg::*;

  logic [NumGpio-1:0] sync1_q;
  logic [NumGpio-1:0] sync2_q;
  logic [NumGpio-1:0] prev_q;
  logic [NumGpio-1:0] out_q;
  logic [NumGpio-1:0] oe_q;
  logic [NumGpio-1:0] intr_en_q;
  logic [NumGpio-1:0] status_q;
  logic [NumGpio-1:0] rise;
  logic               wr_en;

  assign wr_en = bus.valid && bus.write;
  assign rise  = sync2_q & ~prev_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync1_q   <= '0;
      sync2_q   <= '0;
      prev_q    <= '0;
      out_q     <= '0;
      oe_q      <= '0;
      intr_en_q <= '0;
      status_q  <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      if (wr_en && bus.addr == GPIO_OUT) begin
        out_q <= bus.wdata[NumGpio-1:0];
      end
      if (wr_en && bus.addr == GPIO_OE) begin
        oe_q <= bus.wdata[NumGpio-1:0];
      end
      if (wr_en && bus.addr == GPIO_INTR_EN) begin
        intr_en_q <= bus.wdata[NumGpio-1:0];
      end
      // Write one to clear, a new edge wins over the clear
      if (wr_en && bus.addr == GPIO_INTR_STATUS) begin
        status_q <= (status_q & ~bus.wdata[NumGpio-1:0]) | (rise & intr_en_q);
      end else begin
        status_q <= status_q | (rise & intr_en_q);
      end
    end
  end

  always_comb begin
    bus.rdata = '0;
    case (bus.addr)
      GPIO_IN:          bus.rdata[NumGpio-1:0] = sync2_q;
      GPIO_OUT:         bus.rdata[NumGpio-1:0] = out_q;
      GPIO_OE:          bus.rdata[NumGpio-1:0] = oe_q;
      GPIO_INTR_EN:     bus.rdata[NumGpio-1:0] = intr_en_q;
      GPIO_INTR_STATUS: bus.rdata[NumGpio-1:0] = status_q;
      default:          bus.rdata = '0;
    endcase
  end

  assign gpio_o    = out_q;
  assign gpio_en_o = oe_q;
  assign intr_o    = status_q;

endmodule : gpio_regs

// File: source/rv_timer.sv
/*
 * Prescaled 32-bit timer with two level compare interrupts
 */
`timescale 1ns/1ps

module rv_timer (
  input  logic       clk_i,
  input  logic       reset_i,
  reg_bus_if.device  bus,
  output logic [1:0] intr_o
);
  import periph_pkg::*;

  logic                 enable_q;
  logic [31:0]          prescale_q;
  logic [31:0]          presc_cnt_q;
  logic [31:0]          count_q;
  logic [1:0][31:0]     cmp_q;
  logic [1:0]           intr_en_q;
  logic                 tick;
  logic                 wr_en;

  assign wr_en = bus.valid && bus.write;

  // One tick every prescale+1 enabled cycles
  assign tick = enable_q && (presc_cnt_q >= prescale_q);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      enable_q    <= 1'b0;
      prescale_q  <= '0;
      presc_cnt_q <= '0;
      count_q     <= '0;
      cmp_q       <= '1;
      intr_en_q   <= '0;
    end else begin
      if (enable_q) begin
        presc_cnt_q <= tick ? '0 : presc_cnt_q + 32'd1;
      end
      // Software write to COUNT has priority over the tick
      if (wr_en && bus.addr == TMR_COUNT) begin
        count_q <= bus.wdata;
      end else if (tick) begin
        count_q <= count_q + 32'd1;
      end
      if (wr_en) begin
        case (bus.addr)
          TMR_CTRL:     enable_q   <= bus.wdata[0];
          TMR_PRESCALE: prescale_q <= bus.wdata;
          TMR_CMP0:     cmp_q[0]   <= bus.wdata;
          TMR_CMP1:     cmp_q[1]   <= bus.wdata;
          TMR_INTR_EN:  intr_en_q  <= bus.wdata[1:0];
          default:      ;
        endcase
      end
    end
  end

  always_comb begin
    case (bus.addr)
      TMR_CTRL:     bus.rdata = {31'd0, enable_q};
      TMR_PRESCALE: bus.rdata = prescale_q;
      TMR_COUNT:    bus.rdata = count_q;
      TMR_CMP0:     bus.rdata = cmp_q[0];
      TMR_CMP1:     bus.rdata = cmp_q[1];
      TMR_INTR_EN:  bus.rdata = {30'd0, intr_en_q};
      default:      bus.rdata = '0;
    endcase
  end

  // Level stays high until COUNT drops below the compare value
  for (genvar k = 0; k < 2; k++) begin : gen_cmp
    assign intr_o[k] = intr_en_q[k] && (count_q >= cmp_q[k]);
  end

endmodule : rv_timer

// File: source/irq_plic.sv
/*
 * Platform interrupt controller, one target, level gateways,
 * claim/complete and a software interrupt bit
 */
`timescale 1ns/1ps

module irq_plic #(
  parameter int unsigned NumSrc = 15
) (
  input  logic              clk_i,
  input  logic              reset_i,
  reg_bus_if.device         bus,
  input  logic [NumSrc-1:0] intr_src_i,
  output logic              irq_o,
  output logic              msip_o
);
  import periph_pkg::*;

  localparam int unsigned IdWidth = (NumSrc > 1) ? $clog2(NumSrc) : 1;

  logic [PRIO_WIDTH-1:0] prio_q [NumSrc];
  logic [NumSrc-1:0]     pending_q;
  logic [NumSrc-1:0]     enable_q;
  logic [NumSrc-1:0]     in_service_q;
  logic [PRIO_WIDTH-1:0] threshold_q;
  logic                  msip_q;
  logic [IdWidth-1:0]    best_id;
  logic [PRIO_WIDTH-1:0] best_prio;
  logic [NumSrc-1:0]     claim_mask;
  logic [NumSrc-1:0]     complete_mask;
  logic                  wr_en;
  logic                  rd_claim;

  assign wr_en    = bus.valid && bus.write;
  assign rd_claim = bus.valid && !bus.write && (bus.addr == PLIC_CLAIM);

  // Highest priority wins, strict compare keeps ties on the lowest id
  always_comb begin
    best_id   = '0;
    best_prio = '0;
    for (int i = 1; i < NumSrc; i++) begin
      if (pending_q[i] && enable_q[i] && prio_q[i] > best_prio) begin
        best_id   = IdWidth'(i);
        best_prio = prio_q[i];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NumSrc; i++) begin
      claim_mask[i]    = rd_claim && (best_prio != '0) && (best_id == IdWidth'(i));
      complete_mask[i] = wr_en && (bus.addr == PLIC_CLAIM) &&
                         (bus.wdata == BUS_WIDTH'(i));
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < NumSrc; i++) begin
        prio_q[i] <= '0;
      end
      pending_q    <= '0;
      enable_q     <= '0;
      in_service_q <= '0;
      threshold_q  <= '0;
      msip_q       <= 1'b0;
    end else begin
      // Gateway blocks a source while it is in service
      pending_q    <= (pending_q | (intr_src_i & ~in_service_q)) & ~claim_mask;
      in_service_q <= (in_service_q | claim_mask) & ~complete_mask;
      for (int i = 0; i < NumSrc; i++) begin
        if (wr_en && bus.addr == PLIC_PRIO_BASE + REG_ADDR_WIDTH'(4 * i)) begin
          prio_q[i] <= bus.wdata[PRIO_WIDTH-1:0];
        end
      end
      if (wr_en && bus.addr == PLIC_ENABLE) begin
        enable_q <= bus.wdata[NumSrc-1:0];
      end
      if (wr_en && bus.addr == PLIC_THRESHOLD) begin
        threshold_q <= bus.wdata[PRIO_WIDTH-1:0];
      end
      if (wr_en && bus.addr == PLIC_MSIP) begin
        msip_q <= bus.wdata[0];
      end
    end
  end

  always_comb begin
    bus.rdata = '0;
    for (int i = 0; i < NumSrc; i++) begin
      if (bus.addr == PLIC_PRIO_BASE + REG_ADDR_WIDTH'(4 * i)) begin
        bus.rdata[PRIO_WIDTH-1:0] = prio_q[i];
      end
    end
    case (bus.addr)
      PLIC_PENDING:   bus.rdata[NumSrc-1:0]     = pending_q;
      PLIC_ENABLE:    bus.rdata[NumSrc-1:0]     = enable_q;
      PLIC_THRESHOLD: bus.rdata[PRIO_WIDTH-1:0] = threshold_q;
      PLIC_CLAIM:     bus.rdata[IdWidth-1:0]    = best_id;
      PLIC_MSIP:      bus.rdata[0]              = msip_q;
      default:        ;
    endcase
  end

  assign irq_o  = best_prio > threshold_q;
  assign msip_o = msip_q;

endmodule : irq_plic

// File: source/peripheral_subsystem.sv
/*
 * Peripheral subsystem top level
 * OBI bridge, region demux, GPIO, timer and PLIC
 */
`timescale 1ns/1ps

module peripheral_subsystem #(
  parameter int unsigned NumGpio   = 8,
  parameter int unsigned NumExtIrq = 4
) (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             req_i,
  input  logic                             we_i,
  input  logic [periph_pkg::BUS_WIDTH-1:0] addr_i,
  input  logic [periph_pkg::BUS_WIDTH-1:0] wdata_i,
  output logic                             gnt_o,
  output logic                             rvalid_o,
  output logic [periph_pkg::BUS_WIDTH-1:0] rdata_o,
  input  logic [NumGpio-1:0]               gpio_i,
  output logic [NumGpio-1:0]               gpio_o,
  output logic [NumGpio-1:0]               gpio_en_o,
  input  logic [NumExtIrq-1:0]             intr_ext_i,
  output logic [1:0]                       timer_intr_o,
  output logic                             irq_o,
  output logic                             msip_o
);
  import periph_pkg::*;

  // Source 0 reserved, then GPIO, timer and external lines
  localparam int unsigned NumSrc = 1 + NumGpio + 2 + NumExtIrq;

  periph_sel_e       region;
  logic [NumGpio-1:0] gpio_intr;
  logic [NumSrc-1:0]  intr_src;

  reg_bus_if bus_up ();
  reg_bus_if bus_gpio ();
  reg_bus_if bus_timer ();
  reg_bus_if bus_plic ();

  assign intr_src = {intr_ext_i, timer_intr_o, gpio_intr, 1'b0};

  obi_reg_bridge u_obi_reg_bridge (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (req_i),
    .we_i     (we_i),
    .addr_i   (addr_i),
    .wdata_i  (wdata_i),
    .gnt_o    (gnt_o),
    .rvalid_o (rvalid_o),
    .rdata_o  (rdata_o),
    .region_o (region),
    .bus      (bus_up.host)
  );

  periph_reg_demux u_periph_reg_demux (
    .region_i  (region),
    .bus_up    (bus_up.device),
    .bus_gpio  (bus_gpio.host),
    .bus_timer (bus_timer.host),
    .bus_plic  (bus_plic.host)
  );

  gpio_regs #(
    .NumGpio (NumGpio)
  ) u_gpio_regs (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .bus       (bus_gpio.device),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_en_o (gpio_en_o),
    .intr_o    (gpio_intr)
  );

  rv_timer u_rv_timer (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .bus     (bus_timer.device),
    .intr_o  (timer_intr_o)
  );

  irq_plic #(
    .NumSrc (NumSrc)
  ) u_irq_plic (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .bus        (bus_plic.device),
    .intr_src_i (intr_src),
    .irq_o      (irq_o),
    .msip_o     (msip_o)
  );

endmodule : peripheral_subsystem

// File: sim/peripheral_subsystem_props.sv
/*
 * OBI protocol and reset checks, bound into the subsystem top level
 */
`timescale 1ns/1ps

module peripheral_subsystem_props #(
  parameter int unsigned NumGpio = 8
) (
  input logic                             clk_i,
  input logic                             reset_i,
  input logic                             req_i,
  input logic                             gnt_o,
  input logic                             rvalid_o,
  input logic [periph_pkg::BUS_WIDTH-1:0] rdata_o,
  input logic                             irq_o,
  input logic                             msip_o,
  input logic [NumGpio-1:0]               gpio_en_o,
  input logic [1:0]                       timer_intr_o
);

  // Subordinate never stalls
  grant_follows_req : assert property (@(posedge clk_i) gnt_o == req_i)
    else $error("gnt_o differs from req_i");

  resp_after_grant : assert property (
    @(posedge clk_i) disable iff (reset_i) (req_i && gnt_o) |=> rvalid_o
  ) else $error("granted request without rvalid_o one cycle later");

  no_resp_without_grant : assert property (
    @(posedge clk_i) disable iff (reset_i) !req_i |=> !rvalid_o
  ) else $error("rvalid_o without a granted request");

  // Outputs idle in the first cycle out of reset
  idle_after_reset : assert property (
    @(posedge clk_i) $fell(reset_i) |->
      (!rvalid_o && !irq_o && !msip_o && gpio_en_o == '0 && timer_intr_o == '0)
  ) else $error("outputs not inactive right after reset");

  rdata_known : assert property (
    @(posedge clk_i) disable iff (reset_i) rvalid_o |-> !$isunknown(rdata_o)
  ) else $error("rdata_o unknown while rvalid_o is high");

endmodule : peripheral_subsystem_props

// File: sim/tb_peripheral_subsystem.sv
/*
 * Testbench for the peripheral subsystem
 * OBI bus tasks, stimulus for GPIO, timer and PLIC, checking assertions
 */
`timescale 1ns/1ps

module tb_peripheral_subsystem;
  import periph_pkg::*;

  localparam int unsigned NumGpio   = 8;
  localparam int unsigned NumExtIrq = 4;

  logic                 clk_i;
  logic                 reset_i;
  logic                 req_i;
  logic                 we_i;
  logic [BUS_WIDTH-1:0] addr_i;
  logic [BUS_WIDTH-1:0] wdata_i;
  logic                 gnt_o;
  logic                 rvalid_o;
  logic [BUS_WIDTH-1:0] rdata_o;
  logic [NumGpio-1:0]   gpio_i;
  logic [NumGpio-1:0]   gpio_o;
  logic [NumGpio-1:0]   gpio_en_o;
  logic [NumExtIrq-1:0] intr_ext_i;
  logic [1:0]           timer_intr_o;
  logic                 irq_o;
  logic                 msip_o;
  integer               seed;

  peripheral_subsystem #(
    .NumGpio   (NumGpio),
    .NumExtIrq (NumExtIrq)
  ) u_peripheral_subsystem (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_i        (req_i),
    .we_i         (we_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .gnt_o        (gnt_o),
    .rvalid_o     (rvalid_o),
    .rdata_o      (rdata_o),
    .gpio_i       (gpio_i),
    .gpio_o       (gpio_o),
    .gpio_en_o    (gpio_en_o),
    .intr_ext_i   (intr_ext_i),
    .timer_intr_o (timer_intr_o),
    .irq_o        (irq_o),
    .msip_o       (msip_o)
  );

  bind peripheral_subsystem peripheral_subsystem_props #(
    .NumGpio (NumGpio)
  ) u_props (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_i        (req_i),
    .gnt_o        (gnt_o),
    .rvalid_o     (rvalid_o),
    .rdata_o      (rdata_o),
    .irq_o        (irq_o),
    .msip_o       (msip_o),
    .gpio_en_o    (gpio_en_o),
    .timer_intr_o (timer_intr_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      stop_run($sformatf("Mismatch at time %0t: %s, got %h, expected %h",
                         $time, what, got, exp));
    end
  endtask

  // Region in bits 13:12, register offset below
  function automatic logic [31:0] reg_addr(input periph_sel_e sel,
                                           input logic [11:0] offset);
    return {18'd0, sel, offset};
  endfunction

  function automatic logic [31:0] prio_addr(input int id);
    return reg_addr(SEL_PLIC, PLIC_PRIO_BASE + 12'(4 * id));
  endfunction

  // One OBI access, response sampled on the falling edge
  task automatic obi_transfer(input logic we, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
    int cycles;
    cycles = 0;
    @(posedge clk_i);
    req_i   <= 1'b1;
    we_i    <= we;
    addr_i  <= addr;
    wdata_i <= wdata;
    @(posedge clk_i);
    req_i <= 1'b0;
    @(negedge clk_i);
    while (!rvalid_o) begin
      cycles++;
      if (cycles > 20) begin
        stop_run("Timeout: no OBI response within 20 cycles of a request");
      end
      @(negedge clk_i);
    end
    rdata = rdata_o;
  endtask

  task automatic obi_write(input logic [31:0] addr, input logic [31:0] wdata);
    logic [31:0] rsp;
    obi_transfer(1'b1, addr, wdata, rsp);
    check_value("write response data", rsp, 32'd0);
  endtask

  task automatic obi_read(input logic [31:0] addr, output logic [31:0] rdata);
    obi_transfer(1'b0, addr, 32'd0, rdata);
  endtask

  // Reads a register until the masked bits match
  task automatic poll_reg(input logic [31:0] addr, input logic [31:0] mask,
                          input logic [31:0] value, input string what);
    logic [31:0] rd;
    int          polls;
    polls = 0;
    obi_read(addr, rd);
    while ((rd & mask) != value) begin
      polls++;
      if (polls > 20) begin
        stop_run($sformatf("Timeout: %s never reached the expected value", what));
      end
      obi_read(addr, rd);
    end
  endtask

  // CMP1 keeps its all-ones reset value for the whole run
  timer1_low : assert property (@(posedge clk_i) disable iff (reset_i) !timer_intr_o[1])
    else stop_run($sformatf("Mismatch at time %0t: timer_intr_o[1] high", $time));

  initial begin
    logic [31:0] rnd;
    logic [31:0] rd;
    logic [31:0] out_val;
    int          waits;
    seed       = 32'hdd9f_80c3;
    reset_i    = 1'b1;
    req_i      = 1'b0;
    we_i       = 1'b0;
    addr_i     = '0;
    wdata_i    = '0;
    gpio_i     = '0;
    intr_ext_i = '0;
    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;

    // Readback and region decode
    rnd = $random(seed);
    out_val = {24'd0, rnd[7:0]};
    obi_write(reg_addr(SEL_GPIO, GPIO_OUT), rnd);
    obi_read(reg_addr(SEL_GPIO, GPIO_OUT), rd);
    check_value("GPIO_OUT readback", rd, out_val);
    check_value("gpio_o", 32'(gpio_o), out_val);
    rnd = $random(seed);
    obi_write(reg_addr(SEL_GPIO, GPIO_OE), rnd);
    obi_read(reg_addr(SEL_GPIO, GPIO_OE), rd);
    check_value("GPIO_OE readback", rd, {24'd0, rnd[7:0]});
    check_value("gpio_en_o", 32'(gpio_en_o), {24'd0, rnd[7:0]});
    obi_read(reg_addr(SEL_NONE, GPIO_OUT), rd);
    check_value("unmapped region read", rd, 32'd0);
    obi_write(reg_addr(SEL_NONE, GPIO_OUT), ~out_val);
    obi_read(reg_addr(SEL_GPIO, GPIO_OUT), rd);
    check_value("GPIO_OUT after unmapped write", rd, out_val);

    // GPIO input path and edge interrupts, pin 0 enabled, pin 2 not
    @(posedge clk_i);
    gpio_i <= 8'h5a;
    poll_reg(reg_addr(SEL_GPIO, GPIO_IN), 32'hff, 32'h5a, "GPIO_IN");
    obi_write(reg_addr(SEL_GPIO, GPIO_INTR_EN), 32'h01);
    @(posedge clk_i);
    gpio_i <= 8'h5f;
    poll_reg(reg_addr(SEL_GPIO, GPIO_INTR_STATUS), 32'h01, 32'h01, "GPIO status bit 0");
    obi_read(reg_addr(SEL_GPIO, GPIO_INTR_STATUS), rd);
    check_value("GPIO status with pin 2 disabled", rd, 32'h01);
    obi_write(reg_addr(SEL_GPIO, GPIO_INTR_STATUS), 32'h01);
    obi_read(reg_addr(SEL_GPIO, GPIO_INTR_STATUS), rd);
    check_value("GPIO status after clear", rd, 32'h00);

    // Timer compare 0, both compare interrupts enabled
    obi_write(reg_addr(SEL_TIMER, TMR_CMP0), 32'd20);
    obi_write(reg_addr(SEL_TIMER, TMR_INTR_EN), 32'h3);
    obi_write(reg_addr(SEL_TIMER, TMR_PRESCALE), 32'd0);
    obi_write(reg_addr(SEL_TIMER, TMR_CTRL), 32'h1);
    waits = 0;
    @(negedge clk_i);
    while (!timer_intr_o[0]) begin
      waits++;
      if (waits > 200) begin
        stop_run("Timeout: timer_intr_o[0] never rose");
      end
      @(negedge clk_i);
    end
    obi_read(reg_addr(SEL_TIMER, TMR_COUNT), rd);
    assert (rd >= 32'd20) else begin
      stop_run($sformatf("Mismatch at time %0t: COUNT %0d below CMP0", $time, rd));
    end
    obi_write(reg_addr(SEL_TIMER, TMR_COUNT), 32'd0);
    check_value("timer_intr_o[0] after COUNT clear", 32'(timer_intr_o[0]), 32'd0);
    obi_write(reg_addr(SEL_TIMER, TMR_CTRL), 32'h0);

    // PLIC claim order, ext 0 is id 11, ext 1 is id 12
    obi_write(prio_addr(11), 32'd2);
    obi_write(prio_addr(12), 32'd5);
    obi_write(reg_addr(SEL_PLIC, PLIC_ENABLE), 32'h0000_1800);
    obi_write(reg_addr(SEL_PLIC, PLIC_THRESHOLD), 32'd0);
    @(posedge clk_i);
    intr_ext_i <= 4'b0011;
    waits = 0;
    @(negedge clk_i);
    while (!irq_o) begin
      waits++;
      if (waits > 20) begin
        stop_run("Timeout: irq_o never rose for two pending sources");
      end
      @(negedge clk_i);
    end
    obi_read(reg_addr(SEL_PLIC, PLIC_CLAIM), rd);
    check_value("first claim", rd, 32'd12);
    obi_read(reg_addr(SEL_PLIC, PLIC_CLAIM), rd);
    check_value("second claim", rd, 32'd11);
    @(posedge clk_i);
    intr_ext_i <= '0;
    obi_write(reg_addr(SEL_PLIC, PLIC_CLAIM), 32'd12);
    obi_write(reg_addr(SEL_PLIC, PLIC_CLAIM), 32'd11);
    check_value("irq_o after complete", 32'(irq_o), 32'd0);
    obi_read(reg_addr(SEL_PLIC, PLIC_CLAIM), rd);
    check_value("claim with nothing pending", rd, 32'd0);

    // Threshold masking on id 13, then software interrupt
    obi_write(prio_addr(13), 32'd3);
    obi_write(reg_addr(SEL_PLIC, PLIC_ENABLE), 32'h0000_2000);
    obi_write(reg_addr(SEL_PLIC, PLIC_THRESHOLD), 32'd3);
    @(posedge clk_i);
    intr_ext_i <= 4'b0100;
    poll_reg(reg_addr(SEL_PLIC, PLIC_PENDING), 32'h2000, 32'h2000, "PLIC pending id 13");
    check_value("irq_o at threshold", 32'(irq_o), 32'd0);
    obi_write(reg_addr(SEL_PLIC, PLIC_THRESHOLD), 32'd2);
    check_value("irq_o below threshold", 32'(irq_o), 32'd1);
    obi_write(reg_addr(SEL_PLIC, PLIC_MSIP), 32'd1);
    check_value("msip_o set", 32'(msip_o), 32'd1);
    obi_write(reg_addr(SEL_PLIC, PLIC_MSIP), 32'd0);
    check_value("msip_o cleared", 32'(msip_o), 32'd0);

    $display("PASS: all tests");
    $finish;
  end

endmodule : tb_peripheral_subsystem

// File: project.f
source/periph_pkg.sv
source/reg_bus_if.sv
source/obi_reg_bridge.sv
source/periph_reg_demux.sv
source/gpio_regs.sv
source/rv_timer.sv
source/irq_plic.sv
source/peripheral_subsystem.sv
sim/peripheral_subsystem_props.sv
sim/tb_peripheral_subsystem.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_peripheral_subsystem
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
